// File: mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath and storage sizes
`define MIPS_XLEN        32
`define MIPS_REG_COUNT   32
`define MIPS_IMEM_DEPTH  256
`define MIPS_DMEM_DEPTH  256

// Primary opcodes, instr[31:26]
`define MIPS_OP_RTYPE    6'h00
`define MIPS_OP_ADDI     6'h08
`define MIPS_OP_LW       6'h23
`define MIPS_OP_SW       6'h2b
`define MIPS_OP_BEQ      6'h04
`define MIPS_OP_BNE      6'h05
`define MIPS_OP_J        6'h02

// R-type function codes, instr[5:0]
`define MIPS_FN_ADD      6'h20
`define MIPS_FN_SUB      6'h22
`define MIPS_FN_AND      6'h24
`define MIPS_FN_OR       6'h25
`define MIPS_FN_SLT      6'h2a

`endif

// File: mips_pkg.sv
`include "mips_params.svh"

package mips_pkg;

   // Vectors with a meaning of their own
   typedef logic [`MIPS_XLEN-1:0]               word_t;
   typedef logic [$clog2(`MIPS_REG_COUNT)-1:0]  reg_addr_t;
   typedef logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] imem_addr_t;
   typedef logic [$clog2(`MIPS_DMEM_DEPTH)-1:0] dmem_addr_t;

   // ALU function, picked in decode
   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_SLT = 3'd4
   } alu_op_t;

   // Operand source in EX
   typedef enum logic [1:0]
   {
      FWD_NONE = 2'd0,
      FWD_WB   = 2'd1,
      FWD_MEM  = 2'd2
   } fwd_sel_t;

endpackage

// File: mips_reg_file.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_reg_file
(
   input  logic                CLK,
   input  logic                RESET,
   input  mips_pkg::reg_addr_t rs,
   input  mips_pkg::reg_addr_t rt,
   input  logic                we,
   input  mips_pkg::reg_addr_t wr_addr,
   input  mips_pkg::word_t     wr_data,
   input  mips_pkg::reg_addr_t dbg_addr,
   output mips_pkg::word_t     rs_data,
   output mips_pkg::word_t     rt_data,
   output mips_pkg::word_t     dbg_data
);
   import mips_pkg::*;

   // Register 0 has no storage
   word_t regs [1:`MIPS_REG_COUNT-1];

   // Read with bypass of a write in the same cycle
   function automatic word_t read_port(input reg_addr_t addr);
      word_t value;
      if (addr == '0)
         value = '0;
      else if (we && addr == wr_addr)
         value = wr_data;
      else
         value = regs[addr];
      return value;
   endfunction

   always_comb
   begin
      rs_data  = read_port(rs);
      rt_data  = read_port(rt);
      dbg_data = read_port(dbg_addr);
   end

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         for (int i = 1; i < `MIPS_REG_COUNT; i++)
            regs[i] <= '0;
      end
      else if (we && wr_addr != '0)
         regs[wr_addr] <= wr_data;
   end

endmodule

// File: mips_fetch.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_fetch
(
   input  logic                 CLK,
   input  logic                 RESET,
   input  logic                 prog_we,
   input  mips_pkg::imem_addr_t prog_addr,
   input  mips_pkg::word_t      prog_data,
   input  logic                 stall,
   input  logic                 redirect,
   input  mips_pkg::imem_addr_t redirect_pc,
   output mips_pkg::word_t      id_instr,
   output mips_pkg::imem_addr_t id_pc_plus1
);
   import mips_pkg::*;

   word_t      imem [`MIPS_IMEM_DEPTH];
   imem_addr_t pc;
   imem_addr_t pc_plus1;
   imem_addr_t pc_next;
   imem_addr_t imem_addr;
   word_t      if_instr;

   //////////////////////////////////////////////////
   // Program memory

   // The load port borrows the fetch address
   assign imem_addr = prog_we ? prog_addr : pc;
   assign if_instr  = imem[imem_addr];

   always_ff @(posedge CLK)
   begin
      if (prog_we)
         imem[imem_addr] <= prog_data;
   end

   //////////////////////////////////////////////////
   // PC, word addressed

   assign pc_plus1 = pc + 1'b1;
   assign pc_next  = redirect ? redirect_pc : pc_plus1;

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         pc <= '0;
      else if (!stall)
         pc <= pc_next;
   end

   //////////////////////////////////////////////////
   // IF/ID register

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
         id_instr <= '0;
      else if (redirect)
         id_instr <= '0;   // squash the wrong-path fetch
      else if (!stall)
         id_instr <= if_instr;
   end

   always_ff @(posedge CLK)
   begin
      if (!stall)
         id_pc_plus1 <= pc_plus1;
   end

endmodule

// File: mips_decode.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_decode
(
   input  logic                 CLK,
   input  logic                 RESET,
   input  mips_pkg::word_t      id_instr,
   input  mips_pkg::imem_addr_t id_pc_plus1,
   input  logic                 wb_reg_write,
   input  mips_pkg::reg_addr_t  wb_rd,
   input  mips_pkg::word_t      wb_data,
   input  mips_pkg::reg_addr_t  dbg_reg_addr,
   output logic                 stall,
   output logic                 redirect,
   output mips_pkg::imem_addr_t redirect_pc,
   output mips_pkg::word_t      dbg_reg_data,
   output mips_pkg::word_t      ex_rs_data,
   output mips_pkg::word_t      ex_rt_data,
   output mips_pkg::word_t      ex_imm,
   output mips_pkg::reg_addr_t  ex_rs,
   output mips_pkg::reg_addr_t  ex_rt,
   output mips_pkg::reg_addr_t  ex_rd,
   output mips_pkg::alu_op_t    ex_alu_op,
   output logic                 ex_alu_src,
   output logic                 ex_reg_dst,
   output logic                 ex_reg_write,
   output logic                 ex_mem_read,
   output logic                 ex_mem_write,
   output logic                 ex_mem_to_reg
);
   import mips_pkg::*;

   logic [5:0] opcode;
   logic [5:0] funct;
   reg_addr_t  rs;
   reg_addr_t  rt;
   reg_addr_t  rd;
   word_t      imm;
   word_t      rs_data;
   word_t      rt_data;
   alu_op_t    alu_op;
   logic       alu_src;
   logic       reg_dst;
   logic       reg_write;
   logic       mem_read;
   logic       mem_write;
   logic       mem_to_reg;
   logic       is_beq;
   logic       is_bne;
   logic       is_j;
   logic       taken;

   assign opcode = id_instr[31:26];
   assign funct  = id_instr[5:0];
   assign rs     = id_instr[25:21];
   assign rt     = id_instr[20:16];
   assign rd     = id_instr[15:11];
   assign imm    = {{(`MIPS_XLEN-16){id_instr[15]}}, id_instr[15:0]};

   mips_reg_file reg_file0
   (
      .CLK      (CLK),
      .RESET    (RESET),
      .rs       (rs),
      .rt       (rt),
      .we       (wb_reg_write),
      .wr_addr  (wb_rd),
      .wr_data  (wb_data),
      .dbg_addr (dbg_reg_addr),
      .rs_data  (rs_data),
      .rt_data  (rt_data),
      .dbg_data (dbg_reg_data)
   );

   //////////////////////////////////////////////////
   // Control decode

   always_comb
   begin
      alu_op     = ALU_ADD;
      alu_src    = 1'b0;
      reg_dst    = 1'b0;
      reg_write  = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      case (opcode)
         `MIPS_OP_RTYPE:
         begin
            reg_dst   = 1'b1;
            reg_write = 1'b1;
            case (funct)
               `MIPS_FN_ADD: alu_op = ALU_ADD;
               `MIPS_FN_SUB: alu_op = ALU_SUB;
               `MIPS_FN_AND: alu_op = ALU_AND;
               `MIPS_FN_OR:  alu_op = ALU_OR;
               `MIPS_FN_SLT: alu_op = ALU_SLT;
               default:      reg_write = 1'b0;   // all-zero word lands here
            endcase
         end
         `MIPS_OP_ADDI:
         begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         `MIPS_OP_LW:
         begin
            alu_src    = 1'b1;
            reg_write  = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
         end
         `MIPS_OP_SW:
         begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
         end
         default:
         begin
         end
      endcase
   end

   //////////////////////////////////////////////////
   // Branch, jump and load-use stall

   assign is_beq = (opcode == `MIPS_OP_BEQ);
   assign is_bne = (opcode == `MIPS_OP_BNE);
   assign is_j   = (opcode == `MIPS_OP_J);

   // Operands come straight from the register file
   assign taken = (is_beq && rs_data == rt_data) || (is_bne && rs_data != rt_data) || is_j;

   // Load in EX feeding this instruction
   assign stall = ex_mem_read && ex_rt != '0 && (ex_rt == rs || ex_rt == rt);

   assign redirect    = taken && !stall;
   assign redirect_pc = is_j ? imem_addr_t'(id_instr) : id_pc_plus1 + imem_addr_t'(imm);

   //////////////////////////////////////////////////
   // ID/EX register

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         ex_alu_op     <= ALU_ADD;
         ex_alu_src    <= 1'b0;
         ex_reg_dst    <= 1'b0;
         ex_reg_write  <= 1'b0;
         ex_mem_read   <= 1'b0;
         ex_mem_write  <= 1'b0;
         ex_mem_to_reg <= 1'b0;
      end
      else
      begin
         // A stall sends a bubble
         ex_alu_op     <= stall ? ALU_ADD : alu_op;
         ex_alu_src    <= alu_src && !stall;
         ex_reg_dst    <= reg_dst && !stall;
         ex_reg_write  <= reg_write && !stall;
         ex_mem_read   <= mem_read && !stall;
         ex_mem_write  <= mem_write && !stall;
         ex_mem_to_reg <= mem_to_reg && !stall;
      end
   end

   always_ff @(posedge CLK)
   begin
      ex_rs_data <= rs_data;
      ex_rt_data <= rt_data;
      ex_imm     <= imm;
      ex_rs      <= rs;
      ex_rt      <= rt;
      ex_rd      <= rd;
   end

endmodule

// File: mips_execute.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_execute
(
   input  logic                CLK,
   input  logic                RESET,
   input  mips_pkg::word_t     ex_rs_data,
   input  mips_pkg::word_t     ex_rt_data,
   input  mips_pkg::word_t     ex_imm,
   input  mips_pkg::reg_addr_t ex_rs,
   input  mips_pkg::reg_addr_t ex_rt,
   input  mips_pkg::reg_addr_t ex_rd,
   input  mips_pkg::alu_op_t   ex_alu_op,
   input  logic                ex_alu_src,
   input  logic                ex_reg_dst,
   input  logic                ex_reg_write,
   input  logic                ex_mem_read,
   input  logic                ex_mem_write,
   input  logic                ex_mem_to_reg,
   input  mips_pkg::reg_addr_t wb_rd,
   input  logic                wb_reg_write,
   input  mips_pkg::word_t     wb_data,
   output mips_pkg::word_t     mem_alu_result,
   output mips_pkg::word_t     mem_store_data,
   output mips_pkg::reg_addr_t mem_rd,
   output logic                mem_reg_write,
   output logic                mem_mem_read,
   output logic                mem_mem_write,
   output logic                mem_mem_to_reg
);
   import mips_pkg::*;

   fwd_sel_t  fwd_a;
   fwd_sel_t  fwd_b;
   word_t     opnd_a;
   word_t     opnd_b;
   word_t     alu_b;
   word_t     alu_result;
   reg_addr_t dest;

   //////////////////////////////////////////////////
   // Forwarding

   // The younger result in MEM wins over WB
   function automatic fwd_sel_t pick_fwd(input reg_addr_t src);
      fwd_sel_t sel;
      if (mem_reg_write && mem_rd != '0 && mem_rd == src)
         sel = FWD_MEM;
      else if (wb_reg_write && wb_rd != '0 && wb_rd == src)
         sel = FWD_WB;
      else
         sel = FWD_NONE;
      return sel;
   endfunction

   function automatic word_t fwd_value(input fwd_sel_t sel, input word_t reg_value);
      word_t value;
      case (sel)
         FWD_MEM: value = mem_alu_result;
         FWD_WB:  value = wb_data;
         default: value = reg_value;
      endcase
      return value;
   endfunction

   always_comb
   begin
      fwd_a  = pick_fwd(ex_rs);
      fwd_b  = pick_fwd(ex_rt);
      opnd_a = fwd_value(fwd_a, ex_rs_data);
      opnd_b = fwd_value(fwd_b, ex_rt_data);
   end

   //////////////////////////////////////////////////
   // ALU

   assign alu_b = ex_alu_src ? ex_imm : opnd_b;

   always_comb
   begin
      case (ex_alu_op)
         ALU_SUB: alu_result = opnd_a - alu_b;
         ALU_AND: alu_result = opnd_a & alu_b;
         ALU_OR:  alu_result = opnd_a | alu_b;
         ALU_SLT:
            alu_result = {{(`MIPS_XLEN-1){1'b0}}, $signed(opnd_a) < $signed(alu_b)};
         default: alu_result = opnd_a + alu_b;
      endcase
   end

   assign dest = ex_reg_dst ? ex_rd : ex_rt;

   //////////////////////////////////////////////////
   // EX/MEM register

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         mem_reg_write  <= 1'b0;
         mem_mem_read   <= 1'b0;
         mem_mem_write  <= 1'b0;
         mem_mem_to_reg <= 1'b0;
      end
      else
      begin
         mem_reg_write  <= ex_reg_write;
         mem_mem_read   <= ex_mem_read;
         mem_mem_write  <= ex_mem_write;
         mem_mem_to_reg <= ex_mem_to_reg;
      end
   end

   always_ff @(posedge CLK)
   begin
      mem_alu_result <= alu_result;
      mem_store_data <= opnd_b;   // forwarded value, not the stale read
      mem_rd         <= dest;
   end

endmodule

// File: mips_memory.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module mips_memory
(
   input  logic                CLK,
   input  logic                RESET,
   input  mips_pkg::word_t     mem_alu_result,
   input  mips_pkg::word_t     mem_store_data,
   input  mips_pkg::reg_addr_t mem_rd,
   input  logic                mem_reg_write,
   input  logic                mem_mem_read,
   input  logic                mem_mem_write,
   input  logic                mem_mem_to_reg,
   output logic                wb_reg_write,
   output mips_pkg::reg_addr_t wb_rd,
   output mips_pkg::word_t     wb_data
);
   import mips_pkg::*;

   word_t      dmem [`MIPS_DMEM_DEPTH];
   dmem_addr_t dmem_addr;
   word_t      load_data;
   logic       wb_mem_to_reg;
   word_t      wb_load_data;
   word_t      wb_alu_result;

   // Word address from the low bits of the sum
   assign dmem_addr = dmem_addr_t'(mem_alu_result);
   assign load_data = mem_mem_read ? dmem[dmem_addr] : '0;

   always_ff @(posedge CLK)
   begin
      if (mem_mem_write)
         dmem[dmem_addr] <= mem_store_data;
   end

   //////////////////////////////////////////////////
   // MEM/WB register

   always_ff @(posedge CLK or posedge RESET)
   begin
      if (RESET)
      begin
         wb_reg_write  <= 1'b0;
         wb_mem_to_reg <= 1'b0;
      end
      else
      begin
         wb_reg_write  <= mem_reg_write;
         wb_mem_to_reg <= mem_mem_to_reg;
      end
   end

   always_ff @(posedge CLK)
   begin
      wb_load_data  <= load_data;
      wb_alu_result <= mem_alu_result;
      wb_rd         <= mem_rd;
   end

   assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;

endmodule

// File: mips_pipeline.sv
`timescale 1ns/1ns

module mips_pipeline
(
   input  logic                 CLK,
   input  logic                 RESET,
   input  logic                 prog_we,
   input  mips_pkg::imem_addr_t prog_addr,
   input  mips_pkg::word_t      prog_data,
   input  mips_pkg::reg_addr_t  dbg_reg_addr,
   output mips_pkg::word_t      dbg_reg_data
);
   import mips_pkg::*;

   // IF <-> ID
   word_t      id_instr;
   imem_addr_t id_pc_plus1;
   logic       stall;
   logic       redirect;
   imem_addr_t redirect_pc;

   // ID -> EX
   word_t      ex_rs_data;
   word_t      ex_rt_data;
   word_t      ex_imm;
   reg_addr_t  ex_rs;
   reg_addr_t  ex_rt;
   reg_addr_t  ex_rd;
   alu_op_t    ex_alu_op;
   logic       ex_alu_src;
   logic       ex_reg_dst;
   logic       ex_reg_write;
   logic       ex_mem_read;
   logic       ex_mem_write;
   logic       ex_mem_to_reg;

   // EX -> MEM
   word_t      mem_alu_result;
   word_t      mem_store_data;
   reg_addr_t  mem_rd;
   logic       mem_reg_write;
   logic       mem_mem_read;
   logic       mem_mem_write;
   logic       mem_mem_to_reg;

   // Write-back, shared by ID and EX
   logic       wb_reg_write;
   reg_addr_t  wb_rd;
   word_t      wb_data;

   //////////////////////////////////////////////////
   // Stages

   mips_fetch fetch0
   (
      .CLK         (CLK),
      .RESET       (RESET),
      .prog_we     (prog_we),
      .prog_addr   (prog_addr),
      .prog_data   (prog_data),
      .stall       (stall),
      .redirect    (redirect),
      .redirect_pc (redirect_pc),
      .id_instr    (id_instr),
      .id_pc_plus1 (id_pc_plus1)
   );

   mips_decode decode0
   (
      .CLK           (CLK),
      .RESET         (RESET),
      .id_instr      (id_instr),
      .id_pc_plus1   (id_pc_plus1),
      .wb_reg_write  (wb_reg_write),
      .wb_rd         (wb_rd),
      .wb_data       (wb_data),
      .dbg_reg_addr  (dbg_reg_addr),
      .stall         (stall),
      .redirect      (redirect),
      .redirect_pc   (redirect_pc),
      .dbg_reg_data  (dbg_reg_data),
      .ex_rs_data    (ex_rs_data),
      .ex_rt_data    (ex_rt_data),
      .ex_imm        (ex_imm),
      .ex_rs         (ex_rs),
      .ex_rt         (ex_rt),
      .ex_rd         (ex_rd),
      .ex_alu_op     (ex_alu_op),
      .ex_alu_src    (ex_alu_src),
      .ex_reg_dst    (ex_reg_dst),
      .ex_reg_write  (ex_reg_write),
      .ex_mem_read   (ex_mem_read),
      .ex_mem_write  (ex_mem_write),
      .ex_mem_to_reg (ex_mem_to_reg)
   );

   mips_execute execute0
   (
      .CLK            (CLK),
      .RESET          (RESET),
      .ex_rs_data     (ex_rs_data),
      .ex_rt_data     (ex_rt_data),
      .ex_imm         (ex_imm),
      .ex_rs          (ex_rs),
      .ex_rt          (ex_rt),
      .ex_rd          (ex_rd),
      .ex_alu_op      (ex_alu_op),
      .ex_alu_src     (ex_alu_src),
      .ex_reg_dst     (ex_reg_dst),
      .ex_reg_write   (ex_reg_write),
      .ex_mem_read    (ex_mem_read),
      .ex_mem_write   (ex_mem_write),
      .ex_mem_to_reg  (ex_mem_to_reg),
      .wb_rd          (wb_rd),
      .wb_reg_write   (wb_reg_write),
      .wb_data        (wb_data),
      .mem_alu_result (mem_alu_result),
      .mem_store_data (mem_store_data),
      .mem_rd         (mem_rd),
      .mem_reg_write  (mem_reg_write),
      .mem_mem_read   (mem_mem_read),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg)
   );

   mips_memory memory0
   (
      .CLK            (CLK),
      .RESET          (RESET),
      .mem_alu_result (mem_alu_result),
      .mem_store_data (mem_store_data),
      .mem_rd         (mem_rd),
      .mem_reg_write  (mem_reg_write),
      .mem_mem_read   (mem_mem_read),
      .mem_mem_write  (mem_mem_write),
      .mem_mem_to_reg (mem_mem_to_reg),
      .wb_reg_write   (wb_reg_write),
      .wb_rd          (wb_rd),
      .wb_data        (wb_data)
   );

endmodule

// File: tb_mips_pipeline.sv
`timescale 1ns/1ns
`include "mips_params.svh"

module tb_mips_pipeline;
   import mips_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int POLL_LIMIT   = 2000;

   logic       CLK;
   logic       RESET;
   logic       prog_we;
   imem_addr_t prog_addr;
   word_t      prog_data;
   reg_addr_t  dbg_reg_addr;
   word_t      dbg_reg_data;

   // Program table, one flat word list with per-program slices
   word_t       prog_words[$];
   int          prog_first[$];
   int          prog_len[$];
   word_t       prog_marker[$];
   string       prog_name[$];
   logic [15:0] cur_marker;

   // Expected register contents, tagged with their program
   int        exp_prog[$];
   reg_addr_t exp_reg[$];
   word_t     exp_val[$];

   word_t rng_state;
   int    check_count;
   int    error_count;
   int    timeout_count;

   mips_pipeline dut0
   (
      .CLK          (CLK),
      .RESET        (RESET),
      .prog_we      (prog_we),
      .prog_addr    (prog_addr),
      .prog_data    (prog_data),
      .dbg_reg_addr (dbg_reg_addr),
      .dbg_reg_data (dbg_reg_data)
   );

   always #20 CLK = ~CLK;

   //////////////////////////////////////////////////
   // Instruction encoding and reference arithmetic

   function automatic word_t next_random(input word_t x);
      word_t s;
      s = x;
      s = s ^ (s << 13);
      s = s ^ (s >> 17);
      s = s ^ (s << 5);
      return s;
   endfunction

   task automatic draw_imm(output logic [15:0] imm);
      rng_state = next_random(rng_state);
      imm = rng_state[15:0];
   endtask

   function automatic word_t sign_extend(input logic [15:0] imm);
      return {{16{imm[15]}}, imm};
   endfunction

   // Signed less-than from the sign bits and an unsigned compare
   function automatic word_t slt_ref(input word_t x, input word_t y);
      logic lt;
      if (x[31] != y[31])
         lt = x[31];
      else
         lt = (x < y);
      return {31'd0, lt};
   endfunction

   function automatic word_t rtype_instr(input logic [5:0] funct, input int rd,
                                         input int rs, input int rt);
      return {`MIPS_OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, funct};
   endfunction

   // Field order follows the assembler: rt is the destination or second operand
   function automatic word_t itype_instr(input logic [5:0] op, input int rt,
                                         input int rs, input logic [15:0] imm);
      return {op, 5'(rs), 5'(rt), imm};
   endfunction

   function automatic word_t jump_instr(input int target);
      return {`MIPS_OP_J, 18'd0, imem_addr_t'(target)};
   endfunction

   //////////////////////////////////////////////////
   // Table construction

   task automatic begin_program(input string name, input logic [15:0] marker);
      cur_marker = marker;
      prog_first.push_back(prog_words.size());
      prog_len.push_back(0);
      prog_marker.push_back(sign_extend(marker));
      prog_name.push_back(name);
   endtask

   task automatic emit(input word_t instr);
      int last;
      last = prog_len.size() - 1;
      prog_words.push_back(instr);
      prog_len[last] = prog_len[last] + 1;
   endtask

   task automatic expect_reg(input int r, input word_t value);
      exp_prog.push_back(prog_len.size() - 1);
      exp_reg.push_back(reg_addr_t'(r));
      exp_val.push_back(value);
   endtask

   // Marker write to r31, then park on a jump to itself
   task automatic end_program();
      int last;
      last = prog_len.size() - 1;
      emit(itype_instr(`MIPS_OP_ADDI, 31, 0, cur_marker));
      emit(jump_instr(prog_len[last]));
   endtask

   task automatic build_tables();
      logic [15:0] a;
      logic [15:0] b;
      logic [15:0] c;
      word_t       r1;
      word_t       r2;
      word_t       r3;
      word_t       r4;
      word_t       r5;
      word_t       r9;
      int          i;
      draw_imm(a);
      draw_imm(b);
      draw_imm(c);
      r1 = sign_extend(a);
      r2 = sign_extend(b);
      r3 = r1 + r2;
      r4 = r3 - r1;
      r5 = r4 & r3;
      r9 = r3 + sign_extend(c);
      // Dependent chain, each operand one or two instructions old
      begin_program("arith", 16'h0a51);
      emit(itype_instr(`MIPS_OP_ADDI, 1, 0, a));
      emit(itype_instr(`MIPS_OP_ADDI, 2, 0, b));
      emit(rtype_instr(`MIPS_FN_ADD, 3, 1, 2));
      emit(rtype_instr(`MIPS_FN_SUB, 4, 3, 1));
      emit(rtype_instr(`MIPS_FN_AND, 5, 4, 3));
      emit(rtype_instr(`MIPS_FN_OR, 6, 5, 2));
      emit(rtype_instr(`MIPS_FN_SLT, 7, 1, 2));
      emit(rtype_instr(`MIPS_FN_SLT, 8, 2, 1));
      emit(itype_instr(`MIPS_OP_ADDI, 9, 3, c));
      emit(rtype_instr(`MIPS_FN_ADD, 10, 9, 9));
      emit(itype_instr(`MIPS_OP_ADDI, 0, 0, c));
      emit(rtype_instr(`MIPS_FN_ADD, 11, 0, 0));
      end_program();
      expect_reg(0, '0);
      expect_reg(1, r1);
      expect_reg(2, r2);
      expect_reg(3, r3);
      expect_reg(4, r4);
      expect_reg(5, r5);
      expect_reg(6, r5 | r2);
      expect_reg(7, slt_ref(r1, r2));
      expect_reg(8, slt_ref(r2, r1));
      expect_reg(9, r9);
      expect_reg(10, r9 + r9);
      expect_reg(11, '0);

      // Core parked at word 0, so every register must still read zero
      // R31 is covered by the marker poll
      begin_program("reset", 16'h0000);
      emit(jump_instr(0));
      for (i = 0; i < `MIPS_REG_COUNT - 1; i++)
         expect_reg(i, '0);

      draw_imm(a);
      draw_imm(b);
      r1 = sign_extend(a);
      r2 = sign_extend(b);
      begin_program("loadstore", 16'h1c57);
      emit(itype_instr(`MIPS_OP_ADDI, 1, 0, a));
      emit(itype_instr(`MIPS_OP_ADDI, 2, 0, b));
      emit(rtype_instr(`MIPS_FN_ADD, 3, 1, 2));
      emit(itype_instr(`MIPS_OP_SW, 3, 0, 16'd4));
      emit(itype_instr(`MIPS_OP_ADDI, 12, 0, 16'd16));
      emit(itype_instr(`MIPS_OP_SW, 2, 12, 16'd3));
      emit(itype_instr(`MIPS_OP_SW, 1, 0, 16'd5));
      emit(itype_instr(`MIPS_OP_LW, 5, 0, 16'd4));
      emit(rtype_instr(`MIPS_FN_ADD, 6, 5, 1));
      emit(itype_instr(`MIPS_OP_LW, 7, 12, 16'd3));
      emit(itype_instr(`MIPS_OP_LW, 8, 0, 16'd5));
      emit(rtype_instr(`MIPS_FN_ADD, 9, 8, 7));
      end_program();
      expect_reg(3, r1 + r2);
      expect_reg(5, r1 + r2);
      expect_reg(6, r1 + r2 + r1);
      expect_reg(7, r2);
      expect_reg(8, r1);
      expect_reg(9, r1 + r2);
      expect_reg(12, 32'd16);

      // Branch operands are at least three instructions old
      draw_imm(a);
      r1 = sign_extend(a);
      begin_program("branch", 16'h2b0e);
      emit(itype_instr(`MIPS_OP_ADDI, 1, 0, a));
      emit(itype_instr(`MIPS_OP_ADDI, 2, 0, a));
      emit(itype_instr(`MIPS_OP_ADDI, 3, 1, 16'd1));
      emit(itype_instr(`MIPS_OP_ADDI, 20, 0, 16'd1));
      emit(itype_instr(`MIPS_OP_BEQ, 2, 1, 16'd1));
      emit(itype_instr(`MIPS_OP_ADDI, 10, 0, 16'd77));
      emit(itype_instr(`MIPS_OP_BNE, 3, 1, 16'd1));
      emit(itype_instr(`MIPS_OP_ADDI, 11, 0, 16'd78));
      emit(itype_instr(`MIPS_OP_BEQ, 3, 1, 16'd1));
      emit(itype_instr(`MIPS_OP_ADDI, 12, 0, 16'd79));
      emit(itype_instr(`MIPS_OP_BNE, 2, 1, 16'd1));
      emit(itype_instr(`MIPS_OP_ADDI, 13, 0, 16'd80));
      end_program();
      expect_reg(1, r1);
      expect_reg(2, r1);
      expect_reg(3, r1 + 32'd1);
      expect_reg(10, '0);
      expect_reg(11, '0);
      expect_reg(12, 32'd79);
      expect_reg(13, 32'd80);
      expect_reg(20, 32'd1);

      begin_program("jump", 16'h3d1f);
      emit(itype_instr(`MIPS_OP_ADDI, 1, 0, 16'd3));
      emit(jump_instr(4));
      emit(itype_instr(`MIPS_OP_ADDI, 2, 0, 16'd10));
      emit(itype_instr(`MIPS_OP_ADDI, 3, 0, 16'd11));
      emit(itype_instr(`MIPS_OP_ADDI, 4, 1, 16'd1));
      emit(jump_instr(8));
      emit(itype_instr(`MIPS_OP_ADDI, 5, 0, 16'd12));
      emit(itype_instr(`MIPS_OP_ADDI, 6, 0, 16'd13));
      end_program();
      expect_reg(1, 32'd3);
      expect_reg(2, '0);
      expect_reg(3, '0);
      expect_reg(4, 32'd4);
      expect_reg(5, '0);
      expect_reg(6, '0);
   endtask

   //////////////////////////////////////////////////
   // Reset, load, poll and compare

   // RESET high for the whole load, one word per cycle
   task automatic load_program(input int p);
      int i;
      if (prog_len[p] > RESET_CYCLES)
      begin
         error_count++;
         $display("Program %s does not fit in the reset window", prog_name[p]);
      end
      @(posedge CLK);
      RESET        <= 1'b1;
      dbg_reg_addr <= 5'd31;
      for (i = 0; i < RESET_CYCLES; i++)
      begin
         if (i < prog_len[p])
         begin
            prog_we   <= 1'b1;
            prog_addr <= imem_addr_t'(i);
            prog_data <= prog_words[prog_first[p] + i];
         end
         else
            prog_we <= 1'b0;
         @(posedge CLK);
      end
      prog_we <= 1'b0;
      RESET   <= 1'b0;
   endtask

   task automatic wait_for_marker(input int p, output logic found);
      int cycles;
      found  = 1'b0;
      cycles = 0;
      while (!found && cycles < POLL_LIMIT)
      begin
         @(negedge CLK);
         if (dbg_reg_data == prog_marker[p])
            found = 1'b1;
         else
            cycles++;
      end
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      check_count++;
      if (actual !== expected)
      begin
         error_count++;
         $display("Error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_registers(input int p);
      int k;
      for (k = 0; k < exp_prog.size(); k++)
      begin
         if (exp_prog[k] == p)
         begin
            @(posedge CLK);
            dbg_reg_addr <= exp_reg[k];
            @(negedge CLK);
            check_word($sformatf("%s r%0d", prog_name[p], exp_reg[k]),
                       exp_val[k], dbg_reg_data);
         end
      end
   endtask

   initial
   begin
      int   p;
      logic found;
      CLK           = 1'b0;
      RESET         = 1'b1;
      prog_we       = 1'b0;
      prog_addr     = '0;
      prog_data     = '0;
      dbg_reg_addr  = '0;
      rng_state     = 32'd51;
      check_count   = 0;
      error_count   = 0;
      timeout_count = 0;
      build_tables();

      for (p = 0; p < prog_len.size(); p++)
      begin
         load_program(p);
         wait_for_marker(p, found);
         if (found)
            check_registers(p);
         else
         begin
            timeout_count++;
            $display("Timeout: program %s never wrote its end marker to r31", prog_name[p]);
         end
      end

      $display("Checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

// File: mips_pipeline.f
+incdir+.
mips_pkg.sv
mips_reg_file.sv
mips_fetch.sv
mips_decode.sv
mips_execute.sv
mips_memory.sv
mips_pipeline.sv
tb_mips_pipeline.sv

// File: Makefile
# Verilator flow for the pipelined MIPS core

VERILATOR ?= verilator
FILELIST  ?= mips_pipeline.f
TB_TOP    ?= tb_mips_pipeline
RTL_TOP   ?= mips_pipeline
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Verification failed
PASS_MSG  ?= Verification passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
